/* logic/rv_core_cfg.svh */
// --------------------------------------------------
// RV32I core configuration
// data width, register file size, reset and PC step
// --------------------------------------------------
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data and address width
`define RV_XLEN 32

// integer register file
`define RV_NREGS  32
`define RV_REG_AW 5

// fetch sequencing
`define RV_RESET_PC  32'h0000_0000
`define RV_INST_STEP 32'd4

`endif

/* logic/rv_isa_pkg.sv */
// --------------------------------------------------
// RV32I instruction-set encodings
// major opcodes and branch funct3 codes
// --------------------------------------------------
package rv_isa_pkg;

  // major opcode, inst[6:0]
  typedef enum logic [6:0] {
    op_r       = 7'b0110011,  // register-register alu
    op_i_arith = 7'b0010011,  // register-immediate alu
    op_load    = 7'b0000011,  // lw only
    op_jalr    = 7'b1100111,
    op_store   = 7'b0100011,  // sw only
    op_branch  = 7'b1100011,
    op_lui     = 7'b0110111,
    op_jal     = 7'b1101111
  } opcode_t;

  // branch condition, funct3 of a B-type instruction
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,  // signed
    br_ge  = 3'b101,  // signed
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_cond_t;

  // funct3 codes 010 and 011 are not branches
  // the PC unit treats them as never taken

endpackage

/* logic/rv_ctrl_pkg.sv */
// --------------------------------------------------
// internal control encodings of the core
// alu operation, operand and result selects
// --------------------------------------------------
package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic {a_rs1, a_zero} alu_a_sel_t;  // zero feeds lui

  typedef enum logic {b_rs2, b_imm} alu_b_sel_t;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_j, imm_u} imm_kind_t;

  // write-back source
  typedef enum logic [1:0] {wb_alu, wb_load, wb_link} wb_sel_t;

  // next-PC source
  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jal, pc_jalr} pc_sel_t;

endpackage

/* logic/rv_decoder.sv */
// --------------------------------------------------
// rv_decoder: splits the instruction into fields
// and produces all datapath control selects
// --------------------------------------------------
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_decoder
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  logic                  reset,
  input  logic [`RV_XLEN-1:0]   inst,
  output logic [`RV_REG_AW-1:0] rs1,
  output logic [`RV_REG_AW-1:0] rs2,
  output logic [`RV_REG_AW-1:0] rd,
  output alu_op_t               alu_op,
  output alu_a_sel_t            alu_a_sel,
  output alu_b_sel_t            alu_b_sel,
  output imm_kind_t             imm_kind,
  output wb_sel_t               wb_sel,
  output logic                  reg_write,
  output logic                  mem_write,
  output logic                  is_branch,
  output logic                  is_jal,
  output logic                  is_jalr,
  output branch_cond_t          branch_cond
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;      // sub / sra select
  logic       reg_write_raw;
  logic       mem_write_raw;

  assign opcode      = opcode_t'(inst[6:0]);
  assign funct3      = inst[14:12];
  assign funct7_b5   = inst[30];
  assign rs1         = inst[19:15];
  assign rs2         = inst[24:20];
  assign rd          = inst[11:7];
  assign branch_cond = branch_cond_t'(funct3);

  // main decode, unknown opcodes fall through as a no-op
  always_comb begin
    alu_a_sel     = a_rs1;
    alu_b_sel     = b_rs2;
    imm_kind      = imm_i;
    wb_sel        = wb_alu;
    reg_write_raw = 1'b0;
    mem_write_raw = 1'b0;
    is_branch     = 1'b0;
    is_jal        = 1'b0;
    is_jalr       = 1'b0;
    case (opcode)
      op_r: reg_write_raw = 1'b1;
      op_i_arith: begin
        alu_b_sel     = b_imm;
        reg_write_raw = 1'b1;
      end
      op_load: begin
        alu_b_sel     = b_imm;
        wb_sel        = wb_load;
        reg_write_raw = 1'b1;
      end
      op_store: begin
        alu_b_sel     = b_imm;
        imm_kind      = imm_s;
        mem_write_raw = 1'b1;
      end
      op_branch: begin
        imm_kind  = imm_b;    // alu compares rs1 against rs2
        is_branch = 1'b1;
      end
      op_jal: begin
        imm_kind      = imm_j;
        wb_sel        = wb_link;
        reg_write_raw = 1'b1;
        is_jal        = 1'b1;
      end
      op_jalr: begin
        alu_b_sel     = b_imm;  // target = rs1 + imm
        wb_sel        = wb_link;
        reg_write_raw = 1'b1;
        is_jalr       = 1'b1;
      end
      op_lui: begin
        alu_a_sel     = a_zero;
        alu_b_sel     = b_imm;
        imm_kind      = imm_u;
        reg_write_raw = 1'b1;
      end
      default: ;
    endcase
  end

  // alu operation
  always_comb begin
    alu_op = alu_add;
    case (opcode)
      op_r, op_i_arith: begin
        case (funct3)
          3'b000:  alu_op = (opcode == op_r && funct7_b5) ? alu_sub : alu_add;
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = funct7_b5 ? alu_sra : alu_srl;
          3'b110:  alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
      end
      op_branch: alu_op = alu_sub;  // flags drive the branch decision
      default:   alu_op = alu_add;  // address and lui
    endcase
  end

  assign reg_write = reg_write_raw & ~reset;
  assign mem_write = mem_write_raw & ~reset;

endmodule

/* logic/rv_imm_gen.sv */
// --------------------------------------------------
// rv_imm_gen: sign-extended immediates for the
// I, S, B, J and U instruction formats
// --------------------------------------------------
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_imm_gen
  import rv_ctrl_pkg::*;
(
  input  logic [`RV_XLEN-1:0] inst,
  input  imm_kind_t           imm_kind,
  output logic [`RV_XLEN-1:0] imm
);

  logic sign;

  assign sign = inst[31];

  always_comb begin
    case (imm_kind)
      imm_s: imm = {{20{sign}}, inst[31:25], inst[11:7]};
      imm_b: begin
        // bit 0 always zero, halfword aligned
        imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      imm_j: begin
        imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      imm_u:   imm = {inst[31:12], 12'b0};
      default: imm = {{20{sign}}, inst[31:20]};  // I format
    endcase
  end

endmodule

/* logic/rv_regfile.sv */
// --------------------------------------------------
// rv_regfile: integer registers, two combinational
// reads, one clocked write, x0 reads as zero
// --------------------------------------------------
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  we,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rs2,
  input  logic [`RV_REG_AW-1:0] rd,
  input  logic [`RV_XLEN-1:0]   rd_data,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // contents survive reset, only the write is held off
  always_ff @(posedge clk or posedge reset) begin
    if (!reset && we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];  // x0 hardwired
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/rv_alu.sv */
// --------------------------------------------------
// rv_alu: integer ALU with zero, negative, carry
// and overflow flags for branch resolution
// --------------------------------------------------
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_alu
  import rv_ctrl_pkg::*;
(
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  alu_op_t             alu_op,
  output logic [`RV_XLEN-1:0] result,
  output logic                zero,
  output logic                negative,
  output logic                carry,
  output logic                overflow
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] diff;
  logic [SHAMT_W-1:0]  shamt;
  logic                sub_lt;   // signed less-than
  logic                sub_ltu;  // unsigned less-than

  // a - b as a + ~b + 1, carry out set means no borrow
  assign {carry, diff} = {1'b0, a} + {1'b0, ~b} + {{`RV_XLEN{1'b0}}, 1'b1};
  assign overflow      = (a[`RV_XLEN-1] != b[`RV_XLEN-1]) &&
                         (diff[`RV_XLEN-1] != a[`RV_XLEN-1]);
  assign sub_lt        = diff[`RV_XLEN-1] ^ overflow;
  assign sub_ltu       = ~carry;
  assign shamt         = b[SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      alu_sub:  result = diff;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(`RV_XLEN-1){1'b0}}, sub_lt};
      alu_sltu: result = {{(`RV_XLEN-1){1'b0}}, sub_ltu};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = a + b;
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[`RV_XLEN-1];  // equals diff sign on sub

endmodule

/* logic/rv_pc_unit.sv */
// --------------------------------------------------
// rv_pc_unit: program counter, branch decision
// from ALU flags and next-PC selection
// --------------------------------------------------
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_pc_unit
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                is_branch,
  input  logic                is_jal,
  input  logic                is_jalr,
  input  branch_cond_t        branch_cond,
  input  logic                zero,
  input  logic                negative,
  input  logic                carry,
  input  logic                overflow,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] pc
);

  logic                cond_met;
  pc_sel_t             pc_sel;
  logic [`RV_XLEN-1:0] next_pc;

  // flags come from rs1 - rs2
  always_comb begin
    case (branch_cond)
      br_eq:   cond_met = zero;
      br_ne:   cond_met = ~zero;
      br_lt:   cond_met = negative != overflow;
      br_ge:   cond_met = negative == overflow;
      br_ltu:  cond_met = ~carry;   // borrow
      br_geu:  cond_met = carry;
      default: cond_met = 1'b0;
    endcase
  end

  always_comb begin
    if (is_branch && cond_met) pc_sel = pc_branch;
    else if (is_jal)           pc_sel = pc_jal;
    else if (is_jalr)          pc_sel = pc_jalr;
    else                       pc_sel = pc_seq;
  end

  always_comb begin
    case (pc_sel)
      pc_branch, pc_jal: next_pc = pc + imm;
      pc_jalr:           next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
      default:           next_pc = pc + `RV_INST_STEP;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) pc <= `RV_RESET_PC;
    else       pc <= next_pc;
  end

endmodule

/* logic/rv_core.sv */
// --------------------------------------------------
// rv_core: single-cycle RV32I integer core
// --------------------------------------------------
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [`RV_XLEN-1:0] inst,
  input  logic [`RV_XLEN-1:0] mem_rdata,
  output logic [`RV_XLEN-1:0] pc,
  output logic                mem_write,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wdata
);

  logic [`RV_REG_AW-1:0] rs1, rs2, rd;
  alu_op_t               alu_op;
  alu_a_sel_t            alu_a_sel;
  alu_b_sel_t            alu_b_sel;
  imm_kind_t             imm_kind;
  wb_sel_t               wb_sel;
  branch_cond_t          branch_cond;
  logic                  reg_write, is_branch, is_jal, is_jalr;
  logic                  zero, negative, carry, overflow;
  logic [`RV_XLEN-1:0]   imm, rs1_data, rs2_data;
  logic [`RV_XLEN-1:0]   alu_a, alu_b, alu_result, rd_data;

  rv_decoder u_rv_decoder (
    .reset(reset), .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd),
    .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel),
    .imm_kind(imm_kind), .wb_sel(wb_sel), .reg_write(reg_write),
    .mem_write(mem_write), .is_branch(is_branch), .is_jal(is_jal),
    .is_jalr(is_jalr), .branch_cond(branch_cond)
  );

  rv_imm_gen u_rv_imm_gen (.inst(inst), .imm_kind(imm_kind), .imm(imm));

  rv_regfile u_rv_regfile (
    .clk(clk), .reset(reset), .we(reg_write), .rs1(rs1), .rs2(rs2),
    .rd(rd), .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // operand muxes
  assign alu_a = (alu_a_sel == a_zero) ? '0 : rs1_data;   // lui
  assign alu_b = (alu_b_sel == b_imm) ? imm : rs2_data;

  rv_alu u_rv_alu (
    .a(alu_a), .b(alu_b), .alu_op(alu_op), .result(alu_result),
    .zero(zero), .negative(negative), .carry(carry), .overflow(overflow)
  );

  rv_pc_unit u_rv_pc_unit (
    .clk(clk), .reset(reset), .is_branch(is_branch), .is_jal(is_jal),
    .is_jalr(is_jalr), .branch_cond(branch_cond), .zero(zero),
    .negative(negative), .carry(carry), .overflow(overflow), .imm(imm),
    .alu_result(alu_result), .pc(pc)
  );

  // write-back, link value is the return address
  always_comb begin
    case (wb_sel)
      wb_load: rd_data = mem_rdata;
      wb_link: rd_data = pc + `RV_INST_STEP;
      default: rd_data = alu_result;
    endcase
  end

  assign mem_addr  = alu_result;
  assign mem_wdata = rs2_data;

endmodule

/* testbench/rv_core_props.sv */
// --------------------------------------------------
// rv_core_props: reset and pc rules of the core,
// bound onto every rv_core instance
// --------------------------------------------------
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_props (
  input logic                clk,
  input logic                reset,
  input logic [`RV_XLEN-1:0] pc,
  input logic                mem_write
);

  // stores stay masked while the core is held in reset
  a_no_write_in_reset: assert property (@(posedge clk) reset |-> !mem_write)
    else $error("mem_write asserted while reset is high");

  // first edge after release still fetches from the reset vector
  a_pc_after_reset: assert property (@(posedge clk) $fell(reset) |-> pc == `RV_RESET_PC)
    else $error("pc left the reset vector too early");

  a_pc_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(pc))
    else $error("pc holds an unknown value");  // x or z on any bit

endmodule

bind rv_core rv_core_props u_rv_core_props (
  .clk(clk),
  .reset(reset),
  .pc(pc),
  .mem_write(mem_write)
);

/* testbench/rv_core_tb.sv */
// --------------------------------------------------
// rv_core_tb: random RV32I instruction stream run
// against an ISA model, one instruction per clock
// --------------------------------------------------
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_tb;

  localparam int          N_INSTR      = 2000;
  localparam int          RESET_CYCLES = 8;
  localparam int          INIT_CYCLES  = 32;          // lui/addi fill of x1..x31
  localparam int          MAX_CYCLES   = N_INSTR + 100;  // reset plus margin
  localparam logic [31:0] SEED         = 32'd73147;
  localparam logic [4:0]  BASE_REG     = 5'd31;       // data window pointer

  logic        clk, reset, mem_write;
  logic [31:0] inst, mem_rdata, pc, mem_addr, mem_wdata;

  logic [31:0] regs [32];            // model registers
  logic [31:0] dmem [logic [31:0]];  // keyed by word address
  logic [31:0] model_pc, lfsr;
  int          cycles;

  // predictions for the instruction on inst
  logic        exp_store, wr_en;
  logic [4:0]  wr_idx;
  logic [31:0] exp_addr, exp_wdata, exp_rdata, wr_val, next_pc;

  rv_core u_rv_core (
    .clk(clk), .reset(reset), .inst(inst), .mem_rdata(mem_rdata), .pc(pc),
    .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("test timed out after %0d cycles without finishing", cycles);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] imm_i(input logic [31:0] w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic logic [31:0] imm_s(input logic [31:0] w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: return (x < y) ? 32'd1 : 32'd0;
      3'd4: return x ^ y;
      3'd5: begin
        if (alt) return $signed(x) >>> y[4:0];  // sra fills with the sign bit
        return x >> y[4:0];
      end
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] x,
                                      input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (dmem.exists({2'b00, addr[31:2]})) return dmem[{2'b00, addr[31:2]}];
    return '0;  // unwritten words
  endfunction

  function automatic logic [31:0] make_inst(input int n);
    logic [31:0] w;
    logic [3:0]  kind;
    logic [2:0]  f3;
    w = rand_bits(32);
    if (n < INIT_CYCLES - 1) begin
      w[6:0]  = 7'b0110111;  // lui x(n+1)
      w[11:7] = 5'(n + 1);
      if (w[11:7] == BASE_REG) w[31:12] = 20'h00001;  // window at 0x1000
      return w;
    end
    if (n == INIT_CYCLES - 1) return {w[31:20], 5'd1, 3'b000, 5'd1, 7'b0010011};
    kind = 4'(rand_bits(4));
    f3   = w[14:12];
    case (kind)
      0, 1, 2, 3: begin
        w[6:0]   = 7'b0110011;
        w[31:25] = {1'b0, w[30] & (f3 == 3'd0 || f3 == 3'd5), 5'b0};
      end
      4, 5, 6: begin
        w[6:0] = 7'b0010011;
        if (f3 == 3'd1 || f3 == 3'd5) w[31:25] = {1'b0, w[30] & (f3 == 3'd5), 5'b0};
      end
      7: w[6:0] = 7'b0110111;
      8: begin
        w = {7'b0, w[24:22], 2'b00, BASE_REG, 3'b010, w[11:7], 7'b0000011};
      end
      9, 10: begin
        w = {7'b0, w[24:20], BASE_REG, 3'b010, w[9:7], 2'b00, 7'b0100011};
      end
      11, 12: begin
        w[6:0] = 7'b1100011;
        if (f3 == 3'd2 || f3 == 3'd3) w[14] = 1'b1;  // no branch on 010/011
      end
      13: w[6:0] = 7'b1101111;
      14: w[14:0] = {3'b000, w[11:7], 7'b1100111};
      default: w[6:0] = w[0] ? 7'b0001011 : 7'b1110011;  // not implemented
    endcase
    // x31 stays the base pointer so its writes go to x0
    if (w[11:7] == BASE_REG && w[6:0] != 7'b0100011 && w[6:0] != 7'b1100011) w[11:7] = 5'd0;
    return w;
  endfunction

  task automatic predict(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    a         = regs[w[19:15]];
    b         = regs[w[24:20]];
    exp_store = 1'b0;
    exp_addr  = '0;
    exp_wdata = '0;
    exp_rdata = '0;
    wr_en     = 1'b0;
    wr_idx    = w[11:7];
    wr_val    = '0;
    next_pc   = model_pc + 32'd4;
    case (w[6:0])
      7'b0110011: {wr_en, wr_val} = {1'b1, alu_ref(w[14:12], w[30], a, b)};
      7'b0010011: begin
        wr_en  = 1'b1;
        wr_val = alu_ref(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i(w));
      end
      7'b0110111: {wr_en, wr_val} = {1'b1, w[31:12], 12'h000};
      7'b0000011: begin
        exp_addr  = a + imm_i(w);
        exp_rdata = mem_read(exp_addr);
        wr_en     = 1'b1;
        wr_val    = exp_rdata;
      end
      7'b0100011: begin
        exp_store = 1'b1;
        exp_addr  = a + imm_s(w);
        exp_wdata = b;
      end
      7'b1100011: if (branch_ref(w[14:12], a, b)) next_pc = model_pc + imm_b(w);
      7'b1101111: begin
        {wr_en, wr_val} = {1'b1, model_pc + 32'd4};
        next_pc         = model_pc + imm_j(w);
      end
      7'b1100111: begin
        {wr_en, wr_val} = {1'b1, model_pc + 32'd4};
        next_pc         = (a + imm_i(w)) & ~32'd1;
      end
      default: ;
    endcase
  endtask

  initial begin
    logic [31:0] w;
    int          n;
    clk         = 1'b0;
    reset       = 1'b1;
    inst        = 32'h0000_2023;  // sw x0, 0(x0) held during reset
    mem_rdata   = '0;
    lfsr        = SEED;
    cycles      = 0;
    model_pc    = `RV_RESET_PC;
    regs[0]     = '0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_value("pc", `RV_RESET_PC, pc);
      check_value("mem_write", 32'd0, mem_write);
    end
    reset = 1'b0;
    for (n = 0; n < N_INSTR; n++) begin
      check_value("pc", model_pc, pc);
      w = make_inst(n);
      predict(w);
      inst      = w;
      mem_rdata = exp_rdata;
      #4;
      check_value("mem_write", exp_store, mem_write);
      if (exp_store) begin
        check_value("mem_addr", exp_addr, mem_addr);
        check_value("mem_wdata", exp_wdata, mem_wdata);
        dmem[{2'b00, exp_addr[31:2]}] = exp_wdata;
      end
      if (wr_en && wr_idx != 5'd0) regs[wr_idx] = wr_val;
      model_pc = next_pc;
      @(posedge clk);
      #1;
    end
    check_value("pc", model_pc, pc);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/rv_decoder.sv
logic/rv_imm_gen.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_pc_unit.sv
logic/rv_core.sv
testbench/rv_core_props.sv
testbench/rv_core_tb.sv
